// ==== dsp_multicore.f ====
verilog/dsp_types_pkg.sv
verilog/bus_pkg.sv
verilog/coef_regs.sv
verilog/sample_ring.sv
verilog/read_arbiter.sv
verilog/fir_core.sv
verilog/dsp_multicore.sv
sim/dsp_multicore_assert.sv
sim/dsp_multicore_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module dsp_multicore_tb \
	-f dsp_multicore.f \
	-o dsp_multicore_sim

out="$(./obj_dir/dsp_multicore_sim)"
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

// ==== sim/dsp_multicore_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module dsp_multicore_assert #(
	parameter int N = 1
) (
	input logic clk,
	input logic reset,
	input bus_pkg::lite_rd_req_t [N-1:0] req,
	input bus_pkg::lite_rd_rsp_t [N-1:0] rsp,
	input dsp_types_pkg::result_t result,
	input logic result_ready
);

	logic [N-1:0] pending; // Address taken, data not yet returned.
	logic [N-1:0] granted; // Port that holds the read path.

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else begin
			for (int i = 0; i < N; i++) begin
				if (req[i].arvalid && rsp[i].arready) begin
					pending[i] <= 1'b1;
				end else if (rsp[i].rvalid && req[i].rready) begin
					pending[i] <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < N; i++) begin
			granted[i] = pending[i] || (req[i].arvalid && rsp[i].arready);
		end
	end

	for (genvar i = 0; i < N; i++) begin : g_port
		assert property (@(posedge clk) disable iff (reset)
			req[i].arvalid && !rsp[i].arready |=> req[i].arvalid)
			else $error("arvalid dropped before arready on port %0d", i);
		assert property (@(posedge clk) disable iff (reset)
			rsp[i].rvalid && !req[i].rready |=> rsp[i].rvalid)
			else $error("rvalid dropped before rready on port %0d", i);
	end

	assert property (@(posedge clk) disable iff (reset) $onehot0(granted))
		else $error("More than one core granted at once");

	assert property (@(posedge clk) disable iff (reset)
		result.valid && !result_ready |=> result.valid && $stable(result.data))
		else $error("Result changed while waiting for result_ready");

endmodule

bind read_arbiter dsp_multicore_assert #(
	.N(NUM_CORES)
) arbiter_assert_inst (
	.clk(clk),
	.reset(reset),
	.req(core_req),
	.rsp(core_rsp),
	.result('0),
	.result_ready(1'b1)
);

bind fir_core dsp_multicore_assert #(
	.N(1)
) core_assert_inst (
	.clk(clk),
	.reset(reset),
	.req(rd_req),
	.rsp(rd_rsp),
	.result(result),
	.result_ready(result_ready)
);

`default_nettype wire

// ==== sim/dsp_multicore_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dsp_multicore_tb;

	localparam int NUM_CORES = 4;
	localparam int TAPS = 4;
	localparam int NUM_COEFS = NUM_CORES * TAPS;

	typedef enum int {
		E_WRITE,
		E_BUSY_WRITE,
		E_SAMPLE,
		E_END_TEST
	} kind_t;

	typedef struct {
		kind_t kind;
		int addr;
		int value; // Write data or sample.
		logic [NUM_CORES-1:0] ready; // result_ready while the sample runs.
		bit exp_err; // Write should answer SLVERR.
	} entry_t;

	logic clk;
	logic reset;
	logic in_valid;
	dsp_types_pkg::sample_t in_data;
	logic in_ready;
	bus_pkg::lite_wr_req_t host_wr_req;
	bus_pkg::lite_wr_rsp_t host_wr_rsp;
	dsp_types_pkg::result_t [NUM_CORES-1:0] results;
	logic [NUM_CORES-1:0] result_ready;

	entry_t stim[$];
	entry_t held[$]; // Writes issued while the next sample runs.
	int coef_m [NUM_COEFS];
	int hist [TAPS]; // Newest sample first.
	int cycles = 0;
	int limit = 0;
	int checks = 0;
	int errors = 0;
	int test_checks = 0;
	int test_errors = 0;
	string test_names [5] = '{"coefficient writes", "impulse response", "random data",
		"back-pressure", "coefficient update"};

	dsp_multicore #(
		.NUM_CORES(NUM_CORES),
		.TAPS(TAPS)
	) dsp_multicore_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_ready(in_ready),
		.host_wr_req(host_wr_req),
		.host_wr_rsp(host_wr_rsp),
		.results(results),
		.result_ready(result_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles, the DUT stopped responding.", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input int want, input int got);
		checks++;
		test_checks++;
		assert (want == got) else begin
			$display("ERR %0t %s expected %0d actual %0d", $time, name, want, got);
			errors++;
			test_errors++;
		end
	endtask

	// Reference FIR, coefficient k times the sample k steps back.
	function automatic int expected_out(input int core);
		int sum;
		sum = 0;
		for (int k = 0; k < TAPS; k++) begin
			sum += coef_m[core * TAPS + k] * hist[k];
		end
		return sum;
	endfunction

	function automatic void push_entry(input kind_t kind, input int addr, input int value,
		input logic [NUM_CORES-1:0] ready, input bit exp_err);
		entry_t e;
		e.kind = kind;
		e.addr = addr;
		e.value = value;
		e.ready = ready;
		e.exp_err = exp_err;
		stim.push_back(e);
	endfunction

	task automatic write_coef(input int addr, input int value, input bit exp_err);
		@(negedge clk);
		host_wr_req.awvalid = 1'b1;
		host_wr_req.wvalid = 1'b1;
		host_wr_req.awaddr = bus_pkg::addr_t'(addr);
		host_wr_req.wdata = bus_pkg::data_t'(value);
		#1;
		while (!host_wr_rsp.awready) begin
			@(negedge clk);
			#1;
		end
		check_value("wready", 1, int'(host_wr_rsp.wready));
		@(negedge clk);
		host_wr_req.awvalid = 1'b0;
		host_wr_req.wvalid = 1'b0;
		check_value("bvalid", 1, int'(host_wr_rsp.bvalid));
		check_value("bresp", exp_err ? 2 : 0, int'(host_wr_rsp.bresp));
		if (!exp_err) begin
			coef_m[addr] = int'(dsp_types_pkg::coef_t'(value)); // Low 7 bits, signed.
		end
	endtask

	task automatic send_sample(input int value, input logic [NUM_CORES-1:0] ready);
		bit seen [NUM_CORES];
		bit done;
		int want [NUM_CORES];
		entry_t e;
		@(negedge clk);
		check_value("in_ready", 1, int'(in_ready));
		result_ready = ready;
		in_valid = 1'b1;
		in_data = dsp_types_pkg::sample_t'(value);
		@(negedge clk);
		in_valid = 1'b0;
		for (int k = TAPS - 1; k > 0; k--) begin
			hist[k] = hist[k - 1];
		end
		hist[0] = int'(dsp_types_pkg::sample_t'(value));
		for (int c = 0; c < NUM_CORES; c++) begin
			want[c] = expected_out(c);
			seen[c] = 1'b0;
		end
		while (held.size() > 0) begin
			e = held.pop_front();
			write_coef(e.addr, e.value, e.exp_err);
		end
		done = 1'b0;
		while (!done) begin
			done = 1'b1;
			for (int c = 0; c < NUM_CORES; c++) begin
				if (!seen[c] && results[c].valid) begin
					check_value($sformatf("results[%0d].data", c), want[c],
						int'(results[c].data));
					seen[c] = 1'b1;
				end
				done = done && seen[c];
			end
			if (!done) begin
				@(negedge clk);
			end
		end
		if (ready != '1) begin
			repeat (4) begin
				@(negedge clk);
				check_value("in_ready", 0, int'(in_ready));
				for (int c = 0; c < NUM_CORES; c++) begin
					if (!ready[c]) begin
						check_value($sformatf("results[%0d].valid", c), 1,
							int'(results[c].valid));
						check_value($sformatf("results[%0d].data", c), want[c],
							int'(results[c].data));
					end
				end
			end
			result_ready = '1; // Release the stalled cores.
		end
		while (!in_ready) begin
			@(negedge clk);
		end
	endtask

	initial begin
		int test_num;
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		host_wr_req = '0;
		host_wr_req.bready = 1'b1;
		result_ready = '1;
		for (int i = 0; i < NUM_COEFS; i++) begin
			coef_m[i] = 0;
		end
		for (int k = 0; k < TAPS; k++) begin
			hist[k] = 0;
		end
		void'($urandom(18));

		for (int a = 0; a < NUM_COEFS; a++) begin
			push_entry(E_WRITE, a, (a * 9) % 127 - 63, '1, 1'b0);
		end
		push_entry(E_WRITE, NUM_COEFS, 5, '1, 1'b1); // First address past the end.
		push_entry(E_WRITE, 255, -1, '1, 1'b1);
		push_entry(E_END_TEST, 0, 0, '1, 1'b0);

		push_entry(E_SAMPLE, 0, 1, '1, 1'b0);
		for (int k = 0; k < TAPS; k++) begin
			push_entry(E_SAMPLE, 0, 0, '1, 1'b0);
		end
		push_entry(E_END_TEST, 0, 0, '1, 1'b0);

		// Core 0 gets full-scale negative coefficients.
		for (int a = 0; a < NUM_COEFS; a++) begin
			if (a < TAPS) begin
				push_entry(E_WRITE, a, -64, '1, 1'b0);
			end else if (a == TAPS + 1) begin
				push_entry(E_WRITE, a, 63, '1, 1'b0);
			end else begin
				push_entry(E_WRITE, a, int'($urandom_range(127)) - 64, '1, 1'b0);
			end
		end
		for (int k = 0; k < TAPS; k++) begin
			push_entry(E_SAMPLE, 0, -262144, '1, 1'b0);
		end
		push_entry(E_SAMPLE, 0, 262143, '1, 1'b0);
		for (int k = 0; k < 8; k++) begin
			push_entry(E_SAMPLE, 0, int'(dsp_types_pkg::sample_t'($urandom)), '1, 1'b0);
		end
		push_entry(E_END_TEST, 0, 0, '1, 1'b0);

		push_entry(E_SAMPLE, 0, 12345, 4'b1011, 1'b0);
		push_entry(E_SAMPLE, 0, -70000, 4'b0110, 1'b0);
		push_entry(E_SAMPLE, 0, 999, '1, 1'b0);
		push_entry(E_END_TEST, 0, 0, '1, 1'b0);

		push_entry(E_SAMPLE, 0, 4321, '1, 1'b0);
		push_entry(E_WRITE, TAPS, 37, '1, 1'b0);
		push_entry(E_WRITE, 3 * TAPS + 2, -64, '1, 1'b0);
		push_entry(E_BUSY_WRITE, TAPS + 1, -64, '1, 1'b0); // Lands while the cores run.
		push_entry(E_SAMPLE, 0, -8765, '1, 1'b0);
		push_entry(E_SAMPLE, 0, 100, '1, 1'b0);
		push_entry(E_END_TEST, 0, 0, '1, 1'b0);

		limit = stim.size() * (NUM_CORES * TAPS * 4 + 20);

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("in_ready", 1, int'(in_ready));
		check_value("bvalid", 0, int'(host_wr_rsp.bvalid));
		for (int c = 0; c < NUM_CORES; c++) begin
			check_value($sformatf("results[%0d].valid", c), 0, int'(results[c].valid));
		end

		test_num = 0;
		foreach (stim[i]) begin
			case (stim[i].kind)
				E_WRITE: write_coef(stim[i].addr, stim[i].value, stim[i].exp_err);
				E_BUSY_WRITE: held.push_back(stim[i]);
				E_SAMPLE: send_sample(stim[i].value, stim[i].ready);
				default: begin
					$display("Test %0d %s: %0d checks, %0d errors", test_num + 1,
						test_names[test_num], test_checks, test_errors);
					test_num++;
					test_checks = 0;
					test_errors = 0;
				end
			endcase
		end

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	typedef logic [7:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	// AXI4-Lite write channels, master to slave.
	typedef struct packed {
		logic awvalid;
		addr_t awaddr;
		logic wvalid;
		data_t wdata;
		logic bready;
	} lite_wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		resp_t bresp;
	} lite_wr_rsp_t;

	// AXI4-Lite read channels.
	typedef struct packed {
		logic arvalid;
		addr_t araddr;
		logic rready;
	} lite_rd_req_t;

	typedef struct packed {
		logic arready;
		logic rvalid;
		data_t rdata;
		resp_t rresp;
	} lite_rd_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/coef_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module coef_regs #(
	parameter int NUM_CORES = 4,
	parameter int TAPS = 4
) (
	input logic clk,
	input logic reset,
	input bus_pkg::lite_wr_req_t wr_req,
	output bus_pkg::lite_wr_rsp_t wr_rsp,
	output dsp_types_pkg::coef_t [NUM_CORES*TAPS-1:0] coefs
);

	localparam int NUM_COEFS = NUM_CORES * TAPS;
	localparam int COEF_W = $bits(dsp_types_pkg::coef_t);

	logic accept;
	logic addr_ok;
	logic bvalid;
	bus_pkg::resp_t bresp;

	// Address and data are taken on the same edge, one write in flight.
	assign accept = wr_req.awvalid && wr_req.wvalid && !bvalid;
	assign addr_ok = int'(wr_req.awaddr) < NUM_COEFS;

	always_comb begin
		wr_rsp.awready = accept;
		wr_rsp.wready = accept;
		wr_rsp.bvalid = bvalid;
		wr_rsp.bresp = bresp;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid <= 1'b0;
		end else if (accept) begin
			bvalid <= 1'b1;
		end else if (wr_req.bready) begin
			bvalid <= 1'b0; // Response taken.
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			bresp <= addr_ok ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
		end
	end

	// Word address is core * TAPS + tap; out of range matches no slot.
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_COEFS; i++) begin
			if (reset) begin
				coefs[i] <= '0;
			end else if (accept && int'(wr_req.awaddr) == i) begin
				coefs[i] <= dsp_types_pkg::coef_t'(wr_req.wdata[COEF_W-1:0]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dsp_multicore.sv ====
`timescale 1ns/10ps
`default_nettype none

module dsp_multicore #(
	parameter int NUM_CORES = 4,
	parameter int TAPS = 4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input dsp_types_pkg::sample_t in_data,
	output logic in_ready,
	input bus_pkg::lite_wr_req_t host_wr_req,
	output bus_pkg::lite_wr_rsp_t host_wr_rsp,
	output dsp_types_pkg::result_t [NUM_CORES-1:0] results,
	input logic [NUM_CORES-1:0] result_ready
);

	dsp_types_pkg::coef_t [NUM_CORES*TAPS-1:0] coefs;
	bus_pkg::lite_rd_req_t [NUM_CORES-1:0] core_req;
	bus_pkg::lite_rd_rsp_t [NUM_CORES-1:0] core_rsp;
	bus_pkg::lite_rd_req_t ring_req;
	bus_pkg::lite_rd_rsp_t ring_rsp;
	logic [NUM_CORES-1:0] busy;
	logic all_idle;
	logic start;

	assign all_idle = ~|busy; // Every result taken.

	coef_regs #(
		.NUM_CORES(NUM_CORES),
		.TAPS(TAPS)
	) coef_regs_inst (
		.clk(clk),
		.reset(reset),
		.wr_req(host_wr_req),
		.wr_rsp(host_wr_rsp),
		.coefs(coefs)
	);

	sample_ring #(
		.TAPS(TAPS)
	) sample_ring_inst (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_ready(in_ready),
		.all_idle(all_idle),
		.start(start),
		.rd_req(ring_req),
		.rd_rsp(ring_rsp)
	);

	read_arbiter #(
		.NUM_CORES(NUM_CORES),
		.TAPS(TAPS)
	) read_arbiter_inst (
		.clk(clk),
		.reset(reset),
		.core_req(core_req),
		.core_rsp(core_rsp),
		.ring_req(ring_req),
		.ring_rsp(ring_rsp)
	);

	for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
		fir_core #(
			.TAPS(TAPS)
		) fir_core_inst (
			.clk(clk),
			.reset(reset),
			.start(start),
			.coefs(coefs[c*TAPS +: TAPS]),
			.rd_req(core_req[c]),
			.rd_rsp(core_rsp[c]),
			.result(results[c]),
			.result_ready(result_ready[c]),
			.busy(busy[c])
		);
	end

endmodule

`default_nettype wire

// ==== verilog/dsp_types_pkg.sv ====
`default_nettype none

package dsp_types_pkg;

	// Signal path widths.
	typedef logic signed [18:0] sample_t;
	typedef logic signed [6:0] coef_t;
	typedef logic signed [27:0] acc_t;

	// Per-core output, valid held until taken.
	typedef struct packed {
		logic valid;
		acc_t data;
	} result_t;

endpackage

`default_nettype wire

// ==== verilog/fir_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module fir_core #(
	parameter int TAPS = 4
) (
	input logic clk,
	input logic reset,
	input logic start,
	input dsp_types_pkg::coef_t [TAPS-1:0] coefs,
	output bus_pkg::lite_rd_req_t rd_req,
	input bus_pkg::lite_rd_rsp_t rd_rsp,
	output dsp_types_pkg::result_t result,
	input logic result_ready,
	output logic busy
);

	localparam int K_W = (TAPS > 1) ? $clog2(TAPS) : 1;
	localparam int SMP_W = $bits(dsp_types_pkg::sample_t);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA,
		HOLD
	} state_t;

	state_t state;
	logic [K_W-1:0] tap;
	logic last_tap;
	dsp_types_pkg::coef_t [TAPS-1:0] coef_q; // Set in use for this sample.
	dsp_types_pkg::sample_t sample;
	dsp_types_pkg::acc_t product;
	dsp_types_pkg::acc_t acc;

	assign sample = dsp_types_pkg::sample_t'(rd_rsp.rdata[SMP_W-1:0]);
	assign last_tap = int'(tap) == TAPS - 1;

	// A failed read contributes nothing.
	always_comb begin
		if (rd_rsp.rresp == bus_pkg::RESP_OKAY) begin
			product = dsp_types_pkg::acc_t'(coef_q[tap]) * dsp_types_pkg::acc_t'(sample);
		end else begin
			product = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			tap <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= ADDR;
						tap <= '0;
					end
				end
				ADDR: begin
					if (rd_rsp.arready) begin
						state <= DATA;
					end
				end
				DATA: begin
					if (rd_rsp.rvalid) begin
						if (last_tap) begin
							state <= HOLD;
						end else begin
							state <= ADDR;
							tap <= tap + 1'b1;
						end
					end
				end
				HOLD: begin
					if (result_ready) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			coef_q <= coefs;
			acc <= '0;
		end else if (state == DATA && rd_rsp.rvalid) begin
			acc <= acc + product;
		end
	end

	always_comb begin
		rd_req.arvalid = state == ADDR;
		rd_req.araddr = bus_pkg::addr_t'(tap); // Tap k, the sample k steps back.
		rd_req.rready = state == DATA;
	end

	assign result.valid = state == HOLD;
	assign result.data = acc;
	assign busy = state != IDLE;

endmodule

`default_nettype wire

// ==== verilog/read_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_arbiter #(
	parameter int NUM_CORES = 4,
	parameter int TAPS = 4
) (
	input logic clk,
	input logic reset,
	input bus_pkg::lite_rd_req_t [NUM_CORES-1:0] core_req,
	output bus_pkg::lite_rd_rsp_t [NUM_CORES-1:0] core_rsp,
	output bus_pkg::lite_rd_req_t ring_req,
	input bus_pkg::lite_rd_rsp_t ring_rsp
);

	localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

	logic [IDX_W-1:0] rr_ptr; // First core to look at.
	logic [IDX_W-1:0] pick;
	logic [IDX_W-1:0] grant;
	logic [IDX_W-1:0] cur;
	logic pick_valid;
	logic locked; // Grant held until the r handshake.
	logic err_q; // Read decoded here, not sent to the ring.
	logic in_range;
	logic ar_ok;
	logic ar_fire;
	logic resp_valid;
	logic r_fire;

	always_comb begin
		int c;
		c = 0;
		pick = rr_ptr;
		pick_valid = 1'b0;
		for (int i = 0; i < NUM_CORES; i++) begin
			c = int'(rr_ptr) + i;
			if (c >= NUM_CORES) begin
				c = c - NUM_CORES;
			end
			if (!pick_valid && core_req[c].arvalid) begin
				pick_valid = 1'b1;
				pick = IDX_W'(c);
			end
		end
	end

	assign cur = locked ? grant : pick;
	assign in_range = int'(core_req[cur].araddr) < TAPS;
	assign ar_ok = in_range ? ring_rsp.arready : 1'b1;
	assign ar_fire = !locked && pick_valid && ar_ok;
	assign resp_valid = err_q ? 1'b1 : ring_rsp.rvalid;
	assign r_fire = locked && resp_valid && core_req[grant].rready;

	always_comb begin
		ring_req.arvalid = !locked && pick_valid && in_range;
		ring_req.araddr = core_req[cur].araddr;
		ring_req.rready = locked && !err_q && core_req[grant].rready;
	end

	// Only the selected core sees the slave's side of the handshake.
	always_comb begin
		for (int i = 0; i < NUM_CORES; i++) begin
			core_rsp[i] = '0;
		end
		core_rsp[cur].arready = !locked && pick_valid && ar_ok;
		core_rsp[cur].rvalid = locked && resp_valid;
		core_rsp[cur].rdata = err_q ? '0 : ring_rsp.rdata;
		core_rsp[cur].rresp = err_q ? bus_pkg::RESP_SLVERR : ring_rsp.rresp;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			locked <= 1'b0;
			grant <= '0;
			rr_ptr <= '0;
			err_q <= 1'b0;
		end else if (ar_fire) begin
			locked <= 1'b1;
			grant <= pick;
			err_q <= !in_range;
			rr_ptr <= (int'(pick) == NUM_CORES - 1) ? '0 : pick + 1'b1;
		end else if (r_fire) begin
			locked <= 1'b0;
			err_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sample_ring.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_ring #(
	parameter int TAPS = 4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input dsp_types_pkg::sample_t in_data,
	output logic in_ready,
	input logic all_idle,
	output logic start,
	input bus_pkg::lite_rd_req_t rd_req,
	output bus_pkg::lite_rd_rsp_t rd_rsp
);

	localparam int PTR_W = (TAPS > 1) ? $clog2(TAPS) : 1;
	localparam int SMP_W = $bits(dsp_types_pkg::sample_t);
	localparam int EXT_W = $bits(bus_pkg::data_t) - SMP_W;

	dsp_types_pkg::sample_t ring [TAPS];
	dsp_types_pkg::sample_t tap_smp;
	logic [PTR_W-1:0] head; // Next slot to write.
	logic [PTR_W-1:0] slot;
	logic accept;
	logic ar_fire;
	logic tap_ok;
	logic rvalid;
	bus_pkg::data_t rdata;
	bus_pkg::resp_t rresp;

	// Slot of the sample k steps before the newest one.
	function automatic logic [PTR_W-1:0] tap_slot(
		input logic [PTR_W-1:0] hd,
		input bus_pkg::addr_t k
	);
		int s;
		s = int'(hd) - 1 - int'(k);
		if (s < 0) begin
			s = s + TAPS;
		end
		return PTR_W'(s);
	endfunction

	assign in_ready = all_idle && !start; // Blocked until cores go busy.
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			start <= 1'b0;
			for (int i = 0; i < TAPS; i++) begin
				ring[i] <= '0;
			end
		end else begin
			start <= accept;
			if (accept) begin
				ring[head] <= in_data;
				head <= (int'(head) == TAPS - 1) ? '0 : head + 1'b1;
			end
		end
	end

	assign tap_ok = int'(rd_req.araddr) < TAPS;
	assign slot = tap_slot(head, rd_req.araddr);
	assign tap_smp = ring[slot];
	assign ar_fire = rd_req.arvalid && !rvalid;

	always_ff @(posedge clk) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (ar_fire) begin
			rvalid <= 1'b1;
		end else if (rd_req.rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rdata <= tap_ok ? {{EXT_W{tap_smp[SMP_W-1]}}, tap_smp} : '0; // Sign extend.
			rresp <= tap_ok ? bus_pkg::RESP_OKAY : bus_pkg::RESP_SLVERR;
		end
	end

	always_comb begin
		rd_rsp.arready = !rvalid;
		rd_rsp.rvalid = rvalid;
		rd_rsp.rdata = rdata;
		rd_rsp.rresp = rresp;
	end

endmodule

`default_nettype wire
